// File: logic/chol_pkg.sv
package chol_pkg;

    // ------------------------------------------------
    // Fixed point format
    // ------------------------------------------------

    localparam int FRAC_BITS = 16;                // Q16.16

    typedef logic signed [31:0] fixed_t;

    // Lower triangle, row by row. Used for both A and L
    typedef struct packed {
        fixed_t e11;
        fixed_t e21;
        fixed_t e22;
        fixed_t e31;
        fixed_t e32;
        fixed_t e33;
    } chol_mat_t;

    localparam int MAT_WORDS = 6;                 // Words per chol_mat_t

    // Declared MSB first so that busy lands on bit 0 of STATUS
    typedef struct packed {
        logic not_pd;                             // Bit 2
        logic done;                               // Bit 1
        logic busy;                               // Bit 0
    } chol_status_t;

    // ------------------------------------------------
    // APB register map
    // ------------------------------------------------

    localparam int APB_ADDR_W = 8;

    localparam logic [APB_ADDR_W-1:0] REG_CTRL   = 8'h00;   // Bit 0 starts a run
    localparam logic [APB_ADDR_W-1:0] REG_STATUS = 8'h04;
    localparam logic [APB_ADDR_W-1:0] REG_A_BASE = 8'h10;   // Read/write
    localparam logic [APB_ADDR_W-1:0] REG_L_BASE = 8'h30;   // Read only

    // Bytes covered by one matrix window
    localparam logic [APB_ADDR_W-1:0] MAT_SPAN = APB_ADDR_W'(4 * MAT_WORDS);

    // ------------------------------------------------
    // Bit-serial unit lengths
    // ------------------------------------------------

    localparam int SQRT_STEPS = 24;               // Result bits of the root
    localparam int DIV_STEPS  = 48;               // Dividend bits, 32 + FRAC_BITS

endpackage

// File: logic/chol_sqrt.sv
`timescale 1ns/10ps

module chol_sqrt import chol_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   start,
    input  fixed_t radicand,
    output logic   done,
    output fixed_t root
);

    logic [2*SQRT_STEPS-1:0]       bits_q;       // Radicand bits still to consume
    logic [SQRT_STEPS+1:0]         rem_q;
    logic [SQRT_STEPS-1:0]         root_q;
    logic [$clog2(SQRT_STEPS)-1:0] cnt;
    logic                          busy;

    logic [SQRT_STEPS+3:0]         rem_sh;
    logic [SQRT_STEPS+3:0]         trial;
    logic [SQRT_STEPS+3:0]         rem_diff;
    logic [SQRT_STEPS+3:0]         rem_next;
    logic                          fits;

    // One restoring step, two radicand bits in, one root bit out
    assign rem_sh   = {rem_q, bits_q[2*SQRT_STEPS-1 -: 2]};
    assign trial    = {2'b00, root_q, 2'b01};
    assign rem_diff = rem_sh - trial;
    assign fits     = rem_sh >= trial;
    assign rem_next = fits ? rem_diff : rem_sh;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (int'(cnt) == SQRT_STEPS - 1) begin
                    busy <= 1'b0;
                    done <= 1'b1;               // Root already final here
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            bits_q <= {radicand, {FRAC_BITS{1'b0}}};   // Scale keeps Q16.16 after the root
            rem_q  <= '0;
            root_q <= '0;
        end else if (busy) begin
            bits_q <= bits_q << 2;
            rem_q  <= rem_next[SQRT_STEPS+1:0];
            root_q <= {root_q[SQRT_STEPS-2:0], fits};
        end
    end

    assign root = fixed_t'(root_q);              // Held until the next start

endmodule

// File: logic/chol_div.sv
`timescale 1ns/10ps

module chol_div import chol_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   start,
    input  fixed_t dividend,
    input  fixed_t divisor,
    output logic   done,
    output fixed_t quotient
);

    logic [DIV_STEPS-1:0]         q_q;           // Dividend out at the top, quotient in below
    logic [31:0]                  rem_q;
    logic                         neg_q;
    logic [$clog2(DIV_STEPS)-1:0] cnt;
    logic                         busy;

    logic [31:0]                  mag;
    logic [32:0]                  rem_sh;
    logic [32:0]                  rem_diff;
    logic                         fits;
    logic [DIV_STEPS-1:0]         q_next;
    fixed_t                       q_low;

    assign mag = dividend[31] ? -dividend : dividend;   // Also right for the most negative value

    assign rem_sh   = {rem_q, q_q[DIV_STEPS-1]};
    assign rem_diff = rem_sh - {1'b0, divisor};
    assign fits     = rem_sh >= {1'b0, divisor};
    assign q_next   = {q_q[DIV_STEPS-2:0], fits};
    assign q_low    = q_next[31:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (int'(cnt) == DIV_STEPS - 1) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            q_q   <= {mag, {FRAC_BITS{1'b0}}};
            rem_q <= '0;
            neg_q <= dividend[31];
        end else if (busy) begin
            q_q   <= q_next;
            rem_q <= fits ? rem_diff[31:0] : rem_sh[31:0];
            // Last step, sign back on, truncation toward zero
            if (int'(cnt) == DIV_STEPS - 1) begin
                quotient <= neg_q ? -q_low : q_low;
            end
        end
    end

endmodule

// File: logic/chol_sched.sv
`timescale 1ns/10ps

module chol_sched import chol_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  chol_mat_t a_mat,
    output chol_mat_t l_mat,
    output logic      finish,
    output logic      not_pd
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_BASE,                                  // Load a_ij into the running sum
        S_ACC,                                   // Subtract products of known L entries
        S_ISSUE,                                 // PD check, kick sqrt or divide
        S_WAIT
    } state_t;

    state_t             state;
    logic [2:0]         op;                      // Entry being computed, column order
    logic [1:0]         term;
    logic [1:0]         n_terms;
    logic               is_diag;
    fixed_t             acc;
    fixed_t             diag_root;               // Root of the current column
    fixed_t             base;
    fixed_t             mul_a;
    fixed_t             mul_b;
    logic signed [63:0] prod;

    logic               sqrt_start;
    logic               sqrt_done;
    fixed_t             root;
    logic               div_start;
    logic               div_done;
    fixed_t             quotient;
    logic               unit_done;
    fixed_t             result;

    // ------------------------------------------------
    // Per-entry schedule
    // ------------------------------------------------
    // op 0 l11, 1 l21, 2 l31, 3 l22, 4 l32, 5 l33

    always_comb begin
        base    = a_mat.e11;
        n_terms = 2'd0;
        is_diag = 1'b0;
        mul_a   = l_mat.e21;
        mul_b   = l_mat.e21;
        case (op)
            3'd0: begin
                is_diag = 1'b1;
            end
            3'd1: base = a_mat.e21;
            3'd2: base = a_mat.e31;
            3'd3: begin
                base    = a_mat.e22;             // - l21*l21
                is_diag = 1'b1;
                n_terms = 2'd1;
            end
            3'd4: begin
                base    = a_mat.e32;             // - l31*l21
                n_terms = 2'd1;
                mul_a   = l_mat.e31;
            end
            default: begin
                base    = a_mat.e33;             // - l31*l31 - l32*l32
                is_diag = 1'b1;
                n_terms = 2'd2;
                mul_a   = term[0] ? l_mat.e32 : l_mat.e31;
                mul_b   = term[0] ? l_mat.e32 : l_mat.e31;
            end
        endcase
    end

    // Shared multiplier, full width product
    assign prod = 64'(mul_a) * 64'(mul_b);

    assign unit_done = is_diag ? sqrt_done : div_done;
    assign result    = is_diag ? root : quotient;

    // ------------------------------------------------
    // Sequencer
    // ------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= S_IDLE;
            op         <= '0;
            term       <= '0;
            l_mat      <= '0;
            finish     <= 1'b0;
            not_pd     <= 1'b0;
            sqrt_start <= 1'b0;
            div_start  <= 1'b0;
        end else begin
            finish     <= 1'b0;
            sqrt_start <= 1'b0;
            div_start  <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        l_mat  <= '0;            // Entries not reached stay zero
                        not_pd <= 1'b0;
                        op     <= '0;
                        state  <= S_BASE;
                    end
                end
                S_BASE: begin
                    acc   <= base;
                    term  <= '0;
                    state <= S_ACC;
                end
                S_ACC: begin
                    if (term == n_terms) begin
                        state <= S_ISSUE;
                    end else begin
                        acc  <= acc - prod[FRAC_BITS +: 32];   // Bits 47..16
                        term <= term + 1'b1;
                    end
                end
                S_ISSUE: begin
                    if (is_diag && acc <= 0) begin
                        not_pd <= 1'b1;          // Not positive definite
                        finish <= 1'b1;
                        state  <= S_IDLE;
                    end else begin
                        sqrt_start <= is_diag;
                        div_start  <= !is_diag;
                        state      <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (unit_done) begin
                        case (op)
                            3'd0:    l_mat.e11 <= result;
                            3'd1:    l_mat.e21 <= result;
                            3'd2:    l_mat.e31 <= result;
                            3'd3:    l_mat.e22 <= result;
                            3'd4:    l_mat.e32 <= result;
                            default: l_mat.e33 <= result;
                        endcase
                        if (op == 3'(MAT_WORDS - 1)) begin
                            finish <= 1'b1;
                            state  <= S_IDLE;
                        end else begin
                            op    <= op + 1'b1;
                            state <= S_BASE;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Divisor for the entries below the diagonal
    always_ff @(posedge clk) begin
        if (state == S_WAIT && sqrt_done) begin
            diag_root <= root;
        end
    end

    chol_sqrt u_sqrt (
        .clk      (clk),
        .rst      (rst),
        .start    (sqrt_start),
        .radicand (acc),
        .done     (sqrt_done),
        .root     (root)
    );

    chol_div u_div (
        .clk      (clk),
        .rst      (rst),
        .start    (div_start),
        .dividend (acc),
        .divisor  (diag_root),
        .done     (div_done),
        .quotient (quotient)
    );

endmodule

// File: logic/chol_regs.sv
`timescale 1ns/10ps

module chol_regs import chol_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    // APB slave
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [APB_ADDR_W-1:0] paddr,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pslverr,
    // Engine side
    output chol_mat_t             a_mat,
    output logic                  start,
    input  chol_mat_t             l_mat,
    input  logic                  finish,
    input  logic                  not_pd
);

    chol_status_t          status;

    logic                  access;
    logic                  ctrl_hit;
    logic                  stat_hit;
    logic                  a_hit;
    logic                  l_hit;
    logic                  refuse;
    logic                  wr_ok;
    logic [APB_ADDR_W-1:0] a_off;
    logic [APB_ADDR_W-1:0] l_off;
    logic [2:0]            a_idx;
    logic [2:0]            l_idx;

    // Word index to matrix field, in register order
    function automatic fixed_t mat_word(chol_mat_t m, logic [2:0] idx);
        case (idx)
            3'd0:    return m.e11;
            3'd1:    return m.e21;
            3'd2:    return m.e22;
            3'd3:    return m.e31;
            3'd4:    return m.e32;
            default: return m.e33;
        endcase
    endfunction

    // ------------------------------------------------
    // Address decode
    // ------------------------------------------------

    assign access = psel && penable;             // Access phase only

    assign a_off = paddr - REG_A_BASE;
    assign l_off = paddr - REG_L_BASE;
    assign a_idx = a_off[4:2];
    assign l_idx = l_off[4:2];

    assign ctrl_hit = paddr == REG_CTRL;
    assign stat_hit = paddr == REG_STATUS;
    assign a_hit    = paddr >= REG_A_BASE && a_off < MAT_SPAN && paddr[1:0] == 2'b00;
    assign l_hit    = paddr >= REG_L_BASE && l_off < MAT_SPAN && paddr[1:0] == 2'b00;

    // Unmapped, L is read only, and A / CTRL are locked during a run
    assign refuse = !(ctrl_hit || stat_hit || a_hit || l_hit)
                    || (pwrite && (l_hit || (status.busy && (a_hit || ctrl_hit))));

    assign pslverr = access && refuse;
    assign wr_ok   = access && pwrite && !refuse;

    // Read mux, valid in the access cycle
    always_comb begin
        prdata = '0;
        if (stat_hit) begin
            prdata = 32'(status);
        end else if (a_hit) begin
            prdata = mat_word(a_mat, a_idx);
        end else if (l_hit) begin
            prdata = mat_word(l_mat, l_idx);
        end
    end

    // ------------------------------------------------
    // Registers and run status
    // ------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            a_mat  <= '0;
            status <= '0;
            start  <= 1'b0;
        end else begin
            start <= 1'b0;

            if (wr_ok && a_hit) begin
                case (a_idx)
                    3'd0:    a_mat.e11 <= pwdata;
                    3'd1:    a_mat.e21 <= pwdata;
                    3'd2:    a_mat.e22 <= pwdata;
                    3'd3:    a_mat.e31 <= pwdata;
                    3'd4:    a_mat.e32 <= pwdata;
                    default: a_mat.e33 <= pwdata;
                endcase
            end

            if (wr_ok && ctrl_hit && pwdata[0]) begin
                start         <= 1'b1;
                status.busy   <= 1'b1;
                status.done   <= 1'b0;           // Old result flags go away
                status.not_pd <= 1'b0;
            end else if (finish) begin
                status.busy   <= 1'b0;
                status.done   <= 1'b1;
                status.not_pd <= not_pd;
            end
        end
    end

endmodule

// File: logic/cholesky_top.sv
`timescale 1ns/10ps

module cholesky_top import chol_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    // APB slave
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [APB_ADDR_W-1:0] paddr,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pslverr
);

    chol_mat_t a_mat;
    chol_mat_t l_mat;
    logic      start;
    logic      finish;
    logic      not_pd;

    // Host side registers and run status
    chol_regs u_regs (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pslverr (pslverr),
        .a_mat   (a_mat),
        .start   (start),
        .l_mat   (l_mat),
        .finish  (finish),
        .not_pd  (not_pd)
    );

    // Factorization engine
    chol_sched u_sched (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .a_mat  (a_mat),
        .l_mat  (l_mat),
        .finish (finish),
        .not_pd (not_pd)
    );

endmodule

// File: testbench/cholesky_chk.sv
`timescale 1ns/10ps

module cholesky_chk import chol_pkg::*; (
    input logic         clk,
    input logic         rst,
    input logic         psel,
    input logic         penable,
    input logic         pslverr,
    input logic         finish,
    input chol_status_t status
);

    int failures = 0;                            // Watched by the testbench

    // ------------------------------------------------
    // Status flags
    // ------------------------------------------------

    busy_done_excl: assert property (@(posedge clk) disable iff (rst)
        !(status.busy && status.done))
        else begin
            failures++;
            $error("busy and done set together");
        end

    not_pd_needs_done: assert property (@(posedge clk) disable iff (rst)
        status.not_pd |-> status.done)
        else begin
            failures++;
            $error("not_pd set without done");
        end

    // Busy drops one cycle after the finish pulse
    busy_fall_on_finish: assert property (@(posedge clk) disable iff (rst)
        $fell(status.busy) |-> $past(finish))
        else begin
            failures++;
            $error("busy fell without a finish pulse");
        end

    // ------------------------------------------------
    // APB
    // ------------------------------------------------

    slverr_in_access: assert property (@(posedge clk) disable iff (rst)
        pslverr |-> (psel && penable))
        else begin
            failures++;
            $error("pslverr outside an access cycle");
        end

endmodule

bind chol_regs cholesky_chk u_chk (
    .clk     (clk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pslverr (pslverr),
    .finish  (finish),
    .status  (status)
);

// File: testbench/tb_cholesky.sv
`timescale 1ns/10ps

module tb_cholesky import chol_pkg::*; ();

    localparam int     CLK_PERIOD      = 20;
    localparam int     N_RANDOM        = 6;
    localparam int     N_RUNS          = N_RANDOM + 4;
    localparam int     MAX_POLLS       = 200;                   // Two cycles per poll
    localparam int     WATCHDOG_CYCLES = N_RUNS * 400 + 2000;
    localparam fixed_t ONE             = 32'sh0001_0000;

    logic                  clk;
    logic                  rst;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [31:0]           pwdata;
    logic [31:0]           prdata;
    logic                  pslverr;

    int    seed = 32'h4355;
    string l_name [MAT_WORDS] = '{"l11", "l21", "l22", "l31", "l32", "l33"};
    string a_name [MAT_WORDS] = '{"a11", "a21", "a22", "a31", "a32", "a33"};

    cholesky_top DUT (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ------------------------------------------------
    // Reference model
    // ------------------------------------------------

    function automatic fixed_t mul_q16(fixed_t a, fixed_t b);
        longint p;
        p = longint'(a) * longint'(b);
        return fixed_t'(p >>> FRAC_BITS);                       // Bits 47..16
    endfunction

    function automatic fixed_t floor_root(fixed_t x);
        longint target;
        longint r;
        longint t;
        target = longint'(x) <<< FRAC_BITS;
        r = 0;
        for (int b = SQRT_STEPS - 1; b >= 0; b--) begin
            t = r | (longint'(1) << b);
            if (t * t <= target) r = t;
        end
        return fixed_t'(r);
    endfunction

    function automatic fixed_t trunc_div(fixed_t n, fixed_t d);
        longint mag;
        fixed_t q;
        mag = (n < 0) ? -longint'(n) : longint'(n);
        q   = fixed_t'((mag <<< FRAC_BITS) / longint'(d));
        return (n < 0) ? -q : q;                                 // Toward zero
    endfunction

    function automatic void expected_l(input chol_mat_t a, output chol_mat_t l,
                                       output logic npd);
        fixed_t r;
        l   = '0;
        npd = 1'b1;
        r   = a.e11;
        if (r <= 0) return;
        l.e11 = floor_root(r);
        l.e21 = trunc_div(a.e21, l.e11);
        l.e31 = trunc_div(a.e31, l.e11);
        r = a.e22 - mul_q16(l.e21, l.e21);
        if (r <= 0) return;
        l.e22 = floor_root(r);
        l.e32 = trunc_div(a.e32 - mul_q16(l.e31, l.e21), l.e22);
        r = a.e33 - mul_q16(l.e31, l.e31) - mul_q16(l.e32, l.e32);
        if (r <= 0) return;
        l.e33 = floor_root(r);
        npd   = 1'b0;
    endfunction

    function automatic chol_mat_t from_ints(input int v11, v21, v22, v31, v32, v33);
        return {32'(v11 <<< FRAC_BITS), 32'(v21 <<< FRAC_BITS), 32'(v22 <<< FRAC_BITS),
                32'(v31 <<< FRAC_BITS), 32'(v32 <<< FRAC_BITS), 32'(v33 <<< FRAC_BITS)};
    endfunction

    function automatic logic [31:0] word_of(chol_mat_t m, int idx);
        return m[32 * (MAT_WORDS - 1 - idx) +: 32];
    endfunction

    // M*M^T from a random lower triangle, plus 1.0 on the diagonal
    task automatic random_spd(output chol_mat_t a);
        fixed_t m [MAT_WORDS];
        foreach (m[i])
            m[i] = $random(seed) % 196608;                       // Within +-3.0
        a.e11 = mul_q16(m[0], m[0]) + ONE;
        a.e21 = mul_q16(m[1], m[0]);
        a.e22 = mul_q16(m[1], m[1]) + mul_q16(m[2], m[2]) + ONE;
        a.e31 = mul_q16(m[3], m[0]);
        a.e32 = mul_q16(m[3], m[1]) + mul_q16(m[4], m[2]);
        a.e33 = mul_q16(m[3], m[3]) + mul_q16(m[4], m[4]) + mul_q16(m[5], m[5]) + ONE;
    endtask

    // ------------------------------------------------
    // Checks and APB driver
    // ------------------------------------------------

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] data,
                             input logic exp_err);
        psel   = 1'b1;
        pwrite = 1'b1;
        paddr  = addr;
        pwdata = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);                                          // Mid access cycle
        check_word($sformatf("pslverr at %h", addr), 32'(pslverr), 32'(exp_err));
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, output logic [31:0] data,
                            input logic exp_err);
        psel  = 1'b1;
        paddr = addr;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        data = prdata;
        check_word($sformatf("pslverr at %h", addr), 32'(pslverr), 32'(exp_err));
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic load_a(input chol_mat_t a);
        for (int i = 0; i < MAT_WORDS; i++)
            apb_write(REG_A_BASE + 8'(4 * i), word_of(a, i), 1'b0);
    endtask

    task automatic check_l(input chol_mat_t exp_l);
        logic [31:0] got;
        for (int i = 0; i < MAT_WORDS; i++) begin
            apb_read(REG_L_BASE + 8'(4 * i), got, 1'b0);
            check_word(l_name[i], got, word_of(exp_l, i));
        end
    endtask

    task automatic wait_done();
        logic [31:0] st;
        int          polls;
        st    = '0;
        polls = 0;
        while (!st[1] && polls < MAX_POLLS) begin
            apb_read(REG_STATUS, st, 1'b0);
            polls++;
        end
        if (!st[1]) begin
            $display("Run did not finish, STATUS showed no done after %0d polls", polls);
            $display("Simulation failed");
            $fatal(1, "Poll limit reached");
        end
    endtask

    task automatic finish_run(input chol_mat_t exp_l, input logic exp_npd);
        logic [31:0] st;
        wait_done();
        apb_read(REG_STATUS, st, 1'b0);
        check_word("STATUS", st, {29'd0, exp_npd, 2'b10});
        check_l(exp_l);
    endtask

    task automatic run_matrix(input chol_mat_t a, input chol_mat_t exp_l, input logic exp_npd);
        load_a(a);
        apb_write(REG_CTRL, 32'h1, 1'b0);
        finish_run(exp_l, exp_npd);
    endtask

    // ------------------------------------------------
    // Tests
    // ------------------------------------------------

    initial begin
        chol_mat_t   a;
        chol_mat_t   exp_l;
        logic        exp_npd;
        logic [31:0] got;
        clk     = 1'b0;
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        apb_read(REG_STATUS, got, 1'b0);
        check_word("STATUS", got, 32'h0);
        check_l('0);

        run_matrix(from_ints(4, 2, 5, -2, 3, 14), from_ints(2, 1, 2, -1, 2, 3), 1'b0);

        repeat (N_RANDOM) begin
            random_spd(a);
            expected_l(a, exp_l, exp_npd);
            run_matrix(a, exp_l, 1'b0);
        end

        // Second remainder 1 - 4 is negative
        a = from_ints(1, 2, 1, 3, 1, 5);
        expected_l(a, exp_l, exp_npd);
        run_matrix(a, exp_l, 1'b1);

        // Restart right after a not_pd result
        random_spd(a);
        expected_l(a, exp_l, exp_npd);
        load_a(a);
        apb_write(REG_CTRL, 32'h1, 1'b0);
        apb_read(REG_STATUS, got, 1'b0);
        check_word("STATUS", got, 32'h1);
        finish_run(exp_l, 1'b0);

        apb_write(REG_L_BASE + 8'h08, 32'hdead_beef, 1'b1);
        apb_read(8'h08, got, 1'b1);                              // Hole in the map
        check_l(exp_l);

        // A and CTRL locked while busy
        random_spd(a);
        expected_l(a, exp_l, exp_npd);
        load_a(a);
        apb_write(REG_CTRL, 32'h1, 1'b0);
        apb_write(REG_A_BASE, 32'h1234_5678, 1'b1);
        apb_write(REG_CTRL, 32'h1, 1'b1);
        finish_run(exp_l, 1'b0);
        for (int i = 0; i < MAT_WORDS; i++) begin
            apb_read(REG_A_BASE + 8'(4 * i), got, 1'b0);
            check_word(a_name[i], got, word_of(a, i));
        end

        $display("Simulation completed successfully");
        $finish;
    end

    // A bound assertion failure ends the run at once
    always @(DUT.u_regs.u_chk.failures) begin
        if (DUT.u_regs.u_chk.failures != 0) begin
            $display("Bound assertion failed in the register block at %0t ns", $time);
            $display("Simulation failed");
            $fatal(1, "Bound assertion failure");
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run is stuck", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $fatal(1, "Timeout");
    end

endmodule

// File: flist.f
logic/chol_pkg.sv
logic/chol_sqrt.sv
logic/chol_div.sv
logic/chol_sched.sv
logic/chol_regs.sv
logic/cholesky_top.sv
testbench/cholesky_chk.sv
testbench/tb_cholesky.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_cholesky -f flist.f

# Error limit raised so the testbench gets to print its own verdict
out=$(./obj_dir/Vtb_cholesky +verilator+error+limit+100 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "Simulation completed successfully"; then
    exit 0
fi
exit 1
